// ==== axis_fifo.sv ====
//////////////////////////////////////////////////
// synchronous FIFO with registered output stage
// payload type set per instance, beats or lengths
//////////////////////////////////////////////////

`timescale 1ns/1ps

module axis_fifo import lenpre_pkg::*; #(
    parameter type T          = beat_t,
    parameter int  ADDR_WIDTH = DATA_ADDR_WIDTH
) (
    input  logic clk,
    input  logic rst,

    // write side
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,

    // read side
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    // extra msb on each pointer tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    T mem [2**ADDR_WIDTH];

    // registered output stage
    T     out_reg;
    logic out_valid_reg;

    logic full;
    logic empty;
    logic write;
    logic read;

    // same index, different wrap bit
    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign empty = (wr_ptr == rd_ptr);

    assign in_ready = !full;

    // accepted input
    assign write = in_valid && !full;

    // refill when output stage is free or draining this cycle
    assign read = (out_ready || !out_valid_reg) && !empty;

    assign out_data  = out_reg;
    assign out_valid = out_valid_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr        <= '0;
            out_valid_reg <= 1'b0;
        end else if (read) begin
            rd_ptr        <= rd_ptr + 1'b1;
            out_valid_reg <= 1'b1;
        end else if (out_ready) begin
            // taken with nothing behind it
            out_valid_reg <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            out_reg <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // held beat must not change under back-pressure
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

    // upstream offers no write to a full FIFO
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        full |-> !in_valid
    );

endmodule

// ==== axis_if.sv ====
//////////////////////////////////////////////////
// byte stream with valid/ready, tlast and tuser
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface axis_if import lenpre_pkg::*; ();

    logic [DATA_WIDTH-1:0] tdata;
    logic                  tuser;
    logic                  tlast;
    logic                  tvalid;
    logic                  tready;

    // side that produces beats
    modport source (
        output tdata, tuser, tlast, tvalid,
        input  tready
    );

    // side that consumes beats
    modport sink (
        input  tdata, tuser, tlast, tvalid,
        output tready
    );

    // passive observer
    modport monitor (
        input tdata, tuser, tlast, tvalid, tready
    );

endinterface

// ==== frame_len_counter.sv ====
//////////////////////////////////////////////////
// ingress stage, forwards beats to the beat FIFO
// and queues each frame length on its tlast beat
//////////////////////////////////////////////////

`timescale 1ns/1ps

module frame_len_counter import lenpre_pkg::*; (
    axis_if.sink in_if,
    input  logic clk,
    input  logic rst,

    // to beat FIFO
    output beat_t beat_data,
    output logic  beat_valid,
    input  logic  beat_ready,

    // to length FIFO
    output len_t  len_data,
    output logic  len_valid,
    input  logic  len_ready
);

    // beats accepted so far in the current frame
    len_t count;

    logic ingress_ready;
    logic xfer;

    // both FIFOs must have room, so beat and length never split
    assign ingress_ready = beat_ready && len_ready;

    assign in_if.tready = ingress_ready;

    assign xfer = in_if.tvalid && ingress_ready;

    // beat goes straight into storage
    assign beat_data.tlast = in_if.tlast;
    assign beat_data.tuser = in_if.tuser;
    assign beat_data.tdata = in_if.tdata;
    assign beat_valid      = xfer;

    // length includes the tlast beat itself
    assign len_data  = count + 1'b1;
    assign len_valid = xfer && in_if.tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (xfer) begin
            if (in_if.tlast) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // frame longer than the beat FIFO would never drain
    a_frame_len: assert property (
        @(posedge clk) disable iff (rst)
        xfer && !in_if.tlast |=> count < len_t'(MAX_FRAME_LEN)
    );

endmodule

// ==== header_inserter.sv ====
//////////////////////////////////////////////////
// sends one length header beat, then the stored
// frame from the beat FIFO, one frame at a time
//////////////////////////////////////////////////

`timescale 1ns/1ps

module header_inserter import lenpre_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // queued frame lengths
    input  len_t                  len_data,
    input  logic                  len_valid,
    output logic                  len_ready,

    // stored frame beats
    axis_if.sink                  frame_if,

    // egress stream
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic                  m_tuser,
    output logic                  m_tlast,
    output logic                  m_tvalid,
    input  logic                  m_tready
);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next      = state;
        len_ready       = 1'b0;
        frame_if.tready = 1'b0;
        m_tdata         = '0;
        m_tuser         = 1'b0;
        m_tlast         = 1'b0;
        m_tvalid        = 1'b0;

        case (state)
            IDLE: begin
                // a length means the whole frame is already stored
                if (len_valid) begin
                    state_next = HEADER;
                end
            end
            HEADER: begin
                // header byte is the length, no tuser, no tlast
                m_tdata   = len_data;
                m_tvalid  = 1'b1;
                len_ready = m_tready;
                if (m_tready) begin
                    state_next = PAYLOAD;
                end
            end
            PAYLOAD: begin
                // straight pass-through of the stored beats
                m_tdata         = frame_if.tdata;
                m_tuser         = frame_if.tuser;
                m_tlast         = frame_if.tlast;
                m_tvalid        = frame_if.tvalid;
                frame_if.tready = m_tready;
                if (frame_if.tvalid && m_tready && frame_if.tlast) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // length popped only in HEADER and never from an empty FIFO
    a_len_pop: assert property (
        @(posedge clk) disable iff (rst)
        len_ready |-> state == HEADER && len_valid
    );

    // beat FIFO is held until its header has gone out
    a_frame_hold: assert property (
        @(posedge clk) disable iff (rst)
        state != PAYLOAD |-> !frame_if.tready
    );

endmodule

// ==== lenpre_pkg.sv ====
//////////////////////////////////////////////////
// sizes and payload types for the length prepender
// imported by the interface and every RTL module
//////////////////////////////////////////////////

package lenpre_pkg;

    // stream byte width
    localparam int DATA_WIDTH = 8;

    // beat FIFO holds one whole frame
    localparam int DATA_ADDR_WIDTH = 6;

    // a few queued frame lengths
    localparam int LEN_ADDR_WIDTH = 2;

    // longest legal frame, one full beat FIFO
    localparam int MAX_FRAME_LEN = 2 ** DATA_ADDR_WIDTH;

    // one stored beat, tlast on top as in the stream order
    typedef struct packed {
        logic                  tlast;
        logic                  tuser;
        logic [DATA_WIDTH-1:0] tdata;
    } beat_t;

    // frame length in beats, also the header byte
    typedef logic [DATA_WIDTH-1:0] len_t;

endpackage

// ==== lenpre_tb.sv ====
//////////////////////////////////////////////////
// self-checking testbench for the length prepender
// frame table applied in order, random egress stalls
//////////////////////////////////////////////////

`timescale 1ns/1ps

module lenpre_tb import lenpre_pkg::*; ();

    localparam int NUM_ROWS = 14;

    // one frame per row, duty is the m_tready percentage
    typedef struct {
        int len;
        int tuser_mode;
        int duty;
        bit stall_chk;
    } row_t;

    // expected egress beat, header or payload
    typedef struct {
        bit    is_hdr;
        len_t  len;
        beat_t beat;
    } exp_t;

    // tuser mode 0 none, 1 all, 2 odd beats, 3 first beat
    row_t rows [NUM_ROWS] = '{
        '{1, 0, 100, 0},
        '{64, 1, 100, 0},
        '{7, 2, 100, 0},
        // short burst, slow drain, length FIFO fills
        '{2, 0, 10, 0},
        '{2, 1, 10, 0},
        '{2, 2, 10, 0},
        '{2, 3, 10, 0},
        '{2, 0, 10, 0},
        '{2, 1, 10, 0},
        '{2, 2, 10, 0},
        '{2, 3, 10, 1},
        // two max frames, beat FIFO fills
        '{64, 2, 40, 0},
        '{64, 3, 40, 1},
        '{33, 2, 70, 0}
    };

    logic                  clk;
    logic                  rst;
    logic [DATA_WIDTH-1:0] s_tdata;
    logic                  s_tuser;
    logic                  s_tlast;
    logic                  s_tvalid;
    logic                  s_tready;
    logic [DATA_WIDTH-1:0] m_tdata;
    logic                  m_tuser;
    logic                  m_tlast;
    logic                  m_tvalid;
    logic                  m_tready;

    integer   seed;
    int       cur_duty;
    int       stall_cycles;
    int       stall_mark;
    int       pool_idx;
    logic [7:0] byte_pool [256];
    exp_t     exp_q [$];

    lenpre_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_beat(string name, beat_t got, beat_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_len(string name, len_t got, len_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic tuser_for(int mode, int idx);
        case (mode)
            1: return 1'b1;
            2: return idx[0];
            3: return idx == 0;
            default: return 1'b0;
        endcase
    endfunction

    // every beat plus its header, 8 clock periods each
    function automatic int watchdog_ns();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += rows[r].len + 1;
        end
        return total * 20 * 8;
    endfunction

    // called on a falling edge, returns on the one after the transfer
    task automatic send_beat(beat_t b);
        exp_t e;
        s_tdata  = b.tdata;
        s_tuser  = b.tuser;
        s_tlast  = b.tlast;
        s_tvalid = 1'b1;
        // s_tready comes from FIFO state only, stable here
        while (s_tready !== 1'b1) begin
            stall_cycles++;
            @(negedge clk);
        end
        e.is_hdr = 1'b0;
        e.len    = '0;
        e.beat   = b;
        exp_q.push_back(e);
        @(negedge clk);
    endtask

    initial begin : stimulus
        beat_t b;
        exp_t  e;
        seed         = 32'h6157_64c4;
        rst          = 1'b1;
        s_tdata      = '0;
        s_tuser      = 1'b0;
        s_tlast      = 1'b0;
        s_tvalid     = 1'b0;
        m_tready     = 1'b0;
        cur_duty     = 100;
        stall_cycles = 0;
        stall_mark   = 0;
        pool_idx     = 0;
        for (int i = 0; i < 256; i++) begin
            byte_pool[i] = $random(seed);
        end

        // 4 rising edges with reset high
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_flag("m_tvalid after reset", m_tvalid, 1'b0);
        check_flag("s_tready after reset", s_tready, 1'b1);

        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_duty   = rows[r].duty;
            // stalls are counted per frame
            stall_mark = stall_cycles;
            // header precedes the frame at egress
            e.is_hdr = 1'b1;
            e.len    = len_t'(rows[r].len);
            e.beat   = '0;
            exp_q.push_back(e);
            for (int i = 0; i < rows[r].len; i++) begin
                b.tdata = byte_pool[pool_idx];
                b.tuser = tuser_for(rows[r].tuser_mode, i);
                b.tlast = (i == rows[r].len - 1);
                pool_idx++;
                send_beat(b);
            end
            if (rows[r].stall_chk) begin
                if (stall_cycles == stall_mark) begin
                    $display("s_tready never dropped while frame %0d was sent", r);
                    stop_run();
                end
            end
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (m_tvalid !== 1'b0) begin
            $display("extra output beat after the last frame");
            stop_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    // egress back-pressure and checker in one process
    initial begin : egress
        exp_t  e;
        beat_t got;
        beat_t hdr;
        logic  rdy;
        forever begin
            @(negedge clk);
            if (!rst) begin
                rdy      = ($unsigned($random(seed)) % 100) < cur_duty;
                m_tready = rdy;
                // m_* outputs do not depend on m_tready
                if (m_tvalid === 1'b1 && rdy) begin
                    if (exp_q.size() == 0) begin
                        $display("output beat arrived with none expected");
                        stop_run();
                    end
                    e         = exp_q.pop_front();
                    got.tdata = m_tdata;
                    got.tuser = m_tuser;
                    got.tlast = m_tlast;
                    if (e.is_hdr) begin
                        hdr.tdata = e.len;
                        hdr.tuser = 1'b0;
                        hdr.tlast = 1'b0;
                        check_len("m_tdata header", m_tdata, e.len);
                        check_beat("m_* header beat", got, hdr);
                    end else begin
                        check_beat("m_* payload beat", got, e.beat);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns());
        $display("timeout, not all frames came out in time");
        stop_run();
    end

endmodule

// ==== lenpre_top.sv ====
//////////////////////////////////////////////////
// frame length prepender, byte stream in and out
// each frame leaves as a length header plus payload
//////////////////////////////////////////////////

`timescale 1ns/1ps

module lenpre_top import lenpre_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // ingress stream
    input  logic [DATA_WIDTH-1:0] s_tdata,
    input  logic                  s_tuser,
    input  logic                  s_tlast,
    input  logic                  s_tvalid,
    output logic                  s_tready,

    // egress stream
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic                  m_tuser,
    output logic                  m_tlast,
    output logic                  m_tvalid,
    input  logic                  m_tready
);

    axis_if in_if ();
    axis_if mid_if ();

    // counter to beat FIFO
    beat_t wr_beat;
    logic  wr_beat_valid;
    logic  wr_beat_ready;

    // beat FIFO output
    beat_t rd_beat;

    // counter to length FIFO
    len_t  wr_len;
    logic  wr_len_valid;
    logic  wr_len_ready;

    // length FIFO to state machine
    len_t  rd_len;
    logic  rd_len_valid;
    logic  rd_len_ready;

    assign in_if.tdata  = s_tdata;
    assign in_if.tuser  = s_tuser;
    assign in_if.tlast  = s_tlast;
    assign in_if.tvalid = s_tvalid;
    assign s_tready     = in_if.tready;

    frame_len_counter u_counter (
        .in_if      (in_if),
        .clk        (clk),
        .rst        (rst),
        .beat_data  (wr_beat),
        .beat_valid (wr_beat_valid),
        .beat_ready (wr_beat_ready),
        .len_data   (wr_len),
        .len_valid  (wr_len_valid),
        .len_ready  (wr_len_ready)
    );

    // holds one whole frame of beats
    axis_fifo #(
        .T          (beat_t),
        .ADDR_WIDTH (DATA_ADDR_WIDTH)
    ) beat_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (wr_beat),
        .in_valid  (wr_beat_valid),
        .in_ready  (wr_beat_ready),
        .out_data  (rd_beat),
        .out_valid (mid_if.tvalid),
        .out_ready (mid_if.tready)
    );

    assign mid_if.tdata = rd_beat.tdata;
    assign mid_if.tuser = rd_beat.tuser;
    assign mid_if.tlast = rd_beat.tlast;

    // one entry per complete stored frame
    axis_fifo #(
        .T          (len_t),
        .ADDR_WIDTH (LEN_ADDR_WIDTH)
    ) len_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (wr_len),
        .in_valid  (wr_len_valid),
        .in_ready  (wr_len_ready),
        .out_data  (rd_len),
        .out_valid (rd_len_valid),
        .out_ready (rd_len_ready)
    );

    header_inserter u_inserter (
        .clk       (clk),
        .rst       (rst),
        .len_data  (rd_len),
        .len_valid (rd_len_valid),
        .len_ready (rd_len_ready),
        .frame_if  (mid_if),
        .m_tdata   (m_tdata),
        .m_tuser   (m_tuser),
        .m_tlast   (m_tlast),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready)
    );

endmodule

// ==== vlog.f ====
lenpre_pkg.sv
axis_if.sv
axis_fifo.sv
frame_len_counter.sv
header_inserter.sv
lenpre_top.sv
lenpre_tb.sv
